// ==== iagc_pkg.sv ====
package iagc_pkg;

    // ============================================================
    // Sizes
    // ============================================================

    localparam int NUM_CHANNELS    = 4;
    localparam int DATA_SIZE       = 16;
    localparam int ADDR_SIZE       = 6;
    localparam int DEF_MEMORY_SIZE = 64;

    // One extra bit so that a full-depth run of 64 can be stored.
    localparam int SIZE_W          = ADDR_SIZE + 1;
    localparam int CH_W            = $clog2(NUM_CHANNELS);

    // ============================================================
    // State and opcode encodings
    // ============================================================

    // Value 5 is left unused.
    typedef enum logic [3:0] {
        RESET     = 4'd0,
        INIT      = 4'd1,
        IDLE      = 4'd2,
        SAMPLE    = 4'd3,
        CMD_PARSE = 4'd4,
        CMD_ERROR = 4'd6,
        DUMP_MEM  = 4'd7,
        CLEAN_MEM = 4'd8
    } iagc_status_e;

    // Codes 0, 5, 6 and 7 are rejected by the controller.
    typedef enum logic [2:0] {
        OP_SAMPLE  = 3'd1,
        OP_DUMP    = 3'd2,
        OP_CLEAN   = 3'd3,
        OP_SET_MEM = 3'd4
    } iagc_opcode_e;

    typedef enum logic [1:0] {
        DS_IDLE = 2'd0,
        DS_READ = 2'd1,
        DS_SEND = 2'd2,
        DS_DONE = 2'd3
    } dump_state_e;

    // ============================================================
    // Stream payloads
    // ============================================================

    // The opcode field is raw so that invalid codes can reach the parser.
    typedef struct packed {
        logic [2:0]        opcode;
        logic [SIZE_W-1:0] param;
    } iagc_cmd_t;

    typedef struct packed {
        logic [NUM_CHANNELS-1:0][DATA_SIZE-1:0] sample;
    } sample_frame_t;

    typedef struct packed {
        logic [CH_W-1:0]      channel;
        logic [ADDR_SIZE-1:0] addr;
        logic [DATA_SIZE-1:0] data;
    } dump_word_t;

endpackage

// ==== sample_memory.sv ====
`timescale 1ns/1ps

module sample_memory (
    input  logic                            i_clock,
    input  logic                            i_rst_n,
    input  iagc_pkg::iagc_status_e          i_status,
    input  logic                            i_wr_en,
    input  logic [iagc_pkg::ADDR_SIZE-1:0]  i_waddr,
    input  logic [iagc_pkg::DATA_SIZE-1:0]  i_wdata,
    input  logic                            i_rd_en,
    input  logic [iagc_pkg::ADDR_SIZE-1:0]  i_raddr,
    input  logic [iagc_pkg::SIZE_W-1:0]     i_max_addr,
    output logic                            o_clean_end,
    output logic [iagc_pkg::DATA_SIZE-1:0]  o_rdata
);
    import iagc_pkg::*;

    logic [DATA_SIZE-1:0] mem [DEF_MEMORY_SIZE];

    // The clean counter holds the last address already zeroed.
    logic [ADDR_SIZE-1:0] clean_addr;
    logic [ADDR_SIZE-1:0] clean_waddr;
    logic [SIZE_W-1:0]    clean_last;
    logic                 clean_first;
    logic                 clean_active;

    // Nothing has been zeroed yet on the first cycle, so start at address 0.
    assign clean_waddr  = clean_first ? '0 : clean_addr + 1'b1;
    assign clean_last   = i_max_addr - 1'b1;
    assign clean_active = (i_status == CLEAN_MEM) && !o_clean_end;

    // ============================================================
    // Storage
    // ============================================================

    always_ff @(posedge i_clock) begin
        if (i_wr_en) begin
            mem[i_waddr] <= i_wdata;
        end else if (clean_active) begin
            mem[clean_waddr] <= '0;
        end

        if (i_rd_en) begin
            o_rdata <= mem[i_raddr];
        end
    end

    // ============================================================
    // Clean sequence
    // ============================================================

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            clean_addr  <= '0;
            clean_first <= 1'b1;
            o_clean_end <= 1'b0;
        end else if (i_status == CLEAN_MEM) begin
            if (!o_clean_end) begin
                clean_addr  <= clean_waddr;
                clean_first <= 1'b0;
                o_clean_end <= (clean_waddr == clean_last[ADDR_SIZE-1:0]);
            end
        end else begin
            clean_addr  <= '0;
            clean_first <= 1'b1;
            o_clean_end <= 1'b0;
        end
    end

    // A sample write would collide with the clean port on the shared array.
    a_no_write_in_clean: assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        (i_status == CLEAN_MEM) |-> !i_wr_en
    ) else $error("sample write during CLEAN_MEM at address %0d", i_waddr);

endmodule

// ==== iagc_controller.sv ====
`timescale 1ns/1ps

module iagc_controller (
    input  logic                            i_clock,
    input  logic                            i_rst_n,
    input  iagc_pkg::iagc_cmd_t             i_cmd,
    input  logic                            i_cmd_valid,
    output logic                            o_cmd_ready,
    input  iagc_pkg::sample_frame_t         i_frame,
    input  logic                            i_frame_valid,
    output logic                            o_frame_ready,
    input  logic                            i_clean_end,
    input  logic                            i_dump_done,
    output iagc_pkg::iagc_status_e          o_status,
    output logic                            o_cmd_error,
    output logic                            o_wr_en,
    output logic [iagc_pkg::ADDR_SIZE-1:0]  o_waddr,
    output iagc_pkg::sample_frame_t         o_wdata,
    output logic [iagc_pkg::SIZE_W-1:0]     o_max_addr,
    output logic                            o_dump_start
);
    import iagc_pkg::*;

    iagc_status_e         state;
    iagc_status_e         state_next;
    iagc_cmd_t            cmd_q;
    logic [SIZE_W-1:0]    run_size;
    logic [SIZE_W-1:0]    run_last;
    logic [ADDR_SIZE-1:0] wr_cnt;
    logic                 cmd_accept;
    logic                 frame_accept;
    logic                 size_ok;
    logic                 last_frame;

    assign o_cmd_ready   = (state == IDLE);
    assign o_frame_ready = (state == SAMPLE);
    assign cmd_accept    = o_cmd_ready && i_cmd_valid;
    assign frame_accept  = o_frame_ready && i_frame_valid;

    // A run size must be between 1 and the full memory depth.
    assign size_ok    = (cmd_q.param != '0) && (cmd_q.param <= SIZE_W'(DEF_MEMORY_SIZE));
    assign run_last   = run_size - 1'b1;
    assign last_frame = ({1'b0, wr_cnt} == run_last);

    assign o_status    = state;
    assign o_cmd_error = (state == CMD_ERROR);
    assign o_wr_en     = frame_accept;
    assign o_waddr     = wr_cnt;
    assign o_wdata     = i_frame;
    assign o_max_addr  = run_size;

    // ============================================================
    // Status state machine
    // ============================================================

    always_comb begin
        state_next = state;
        case (state)
            RESET: begin
                state_next = INIT;
            end
            INIT: begin
                state_next = CLEAN_MEM;
            end
            IDLE: begin
                if (cmd_accept) begin
                    state_next = CMD_PARSE;
                end
            end
            CMD_PARSE: begin
                case (cmd_q.opcode)
                    OP_SAMPLE:  state_next = SAMPLE;
                    OP_DUMP:    state_next = DUMP_MEM;
                    OP_CLEAN:   state_next = CLEAN_MEM;
                    OP_SET_MEM: state_next = size_ok ? IDLE : CMD_ERROR;
                    default:    state_next = CMD_ERROR;
                endcase
            end
            SAMPLE: begin
                if (frame_accept && last_frame) begin
                    state_next = IDLE;
                end
            end
            CMD_ERROR: begin
                state_next = IDLE;
            end
            DUMP_MEM: begin
                if (i_dump_done) begin
                    state_next = IDLE;
                end
            end
            CLEAN_MEM: begin
                if (i_clean_end) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = RESET;
            end
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            state        <= RESET;
            run_size     <= '0;
            wr_cnt       <= '0;
            o_dump_start <= 1'b0;
        end else begin
            state        <= state_next;
            // High on the first DUMP_MEM cycle only.
            o_dump_start <= (state == CMD_PARSE) && (state_next == DUMP_MEM);

            if (state == INIT) begin
                run_size <= SIZE_W'(DEF_MEMORY_SIZE);
            end else if ((state == CMD_PARSE) && (cmd_q.opcode == OP_SET_MEM) && size_ok) begin
                run_size <= cmd_q.param;
            end

            if (state == CMD_PARSE) begin
                wr_cnt <= '0;
            end else if (frame_accept) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
        end
    end

    // Command register, loaded on the accepting edge and parsed next cycle.
    always_ff @(posedge i_clock) begin
        if (cmd_accept) begin
            cmd_q <= i_cmd;
        end
    end

    // While frames are offered the write address stays inside the run.
    a_frame_ready_in_run: assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        o_frame_ready |-> ({1'b0, wr_cnt} < run_size)
    ) else $error("frame ready at address %0d past run size %0d", wr_cnt, run_size);

endmodule

// ==== dump_serializer.sv ====
`timescale 1ns/1ps

module dump_serializer (
    input  logic                                                    i_clock,
    input  logic                                                    i_rst_n,
    input  logic                                                    i_dump_start,
    input  logic [iagc_pkg::SIZE_W-1:0]                             i_max_addr,
    output logic                                                    o_rd_en,
    output logic [iagc_pkg::ADDR_SIZE-1:0]                          o_raddr,
    input  logic [iagc_pkg::NUM_CHANNELS-1:0][iagc_pkg::DATA_SIZE-1:0] i_rdata,
    output iagc_pkg::dump_word_t                                    o_dump,
    output logic                                                    o_dump_valid,
    input  logic                                                    i_dump_ready,
    output logic                                                    o_dump_done
);
    import iagc_pkg::*;

    dump_state_e          state;
    logic [ADDR_SIZE-1:0] addr;
    logic [CH_W-1:0]      ch;
    logic [SIZE_W-1:0]    last_full;
    logic                 last_addr;
    logic                 last_ch;
    logic                 word_taken;

    assign last_full  = i_max_addr - 1'b1;
    assign last_addr  = (addr == last_full[ADDR_SIZE-1:0]);
    assign last_ch    = (ch == CH_W'(NUM_CHANNELS - 1));
    assign word_taken = o_dump_valid && i_dump_ready;

    assign o_rd_en      = (state == DS_READ);
    assign o_raddr      = addr;
    assign o_dump_valid = (state == DS_SEND);
    assign o_dump_done  = (state == DS_DONE);

    // The memories keep their read register until the next read, so the
    // row stays put while the channels are sent.
    always_comb begin
        o_dump.channel = ch;
        o_dump.addr    = addr;
        o_dump.data    = i_rdata[ch];
    end

    // ============================================================
    // Read and send sequence
    // ============================================================

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            state <= DS_IDLE;
            addr  <= '0;
            ch    <= '0;
        end else begin
            case (state)
                DS_IDLE: begin
                    if (i_dump_start) begin
                        addr  <= '0;
                        ch    <= '0;
                        state <= DS_READ;
                    end
                end
                DS_READ: begin
                    state <= DS_SEND;
                end
                DS_SEND: begin
                    if (word_taken) begin
                        if (last_ch) begin
                            ch <= '0;
                            if (last_addr) begin
                                state <= DS_DONE;
                            end else begin
                                addr  <= addr + 1'b1;
                                state <= DS_READ;
                            end
                        end else begin
                            ch <= ch + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= DS_IDLE;
                end
            endcase
        end
    end

    a_hold_under_backpressure: assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        (o_dump_valid && !i_dump_ready) |=> (o_dump_valid && $stable(o_dump))
    ) else $error("dump word changed while stalled");

endmodule

// ==== iagc_top.sv ====
`timescale 1ns/1ps

module iagc_top (
    input  logic                       i_clock,
    input  logic                       i_rst_n,
    input  iagc_pkg::iagc_cmd_t        i_cmd,
    input  logic                       i_cmd_valid,
    output logic                       o_cmd_ready,
    input  iagc_pkg::sample_frame_t    i_frame,
    input  logic                       i_frame_valid,
    output logic                       o_frame_ready,
    output iagc_pkg::dump_word_t       o_dump,
    output logic                       o_dump_valid,
    input  logic                       i_dump_ready,
    output iagc_pkg::iagc_status_e     o_status,
    output logic                       o_cmd_error
);
    import iagc_pkg::*;

    logic                                   wr_en;
    logic [ADDR_SIZE-1:0]                   waddr;
    sample_frame_t                          wdata;
    logic [SIZE_W-1:0]                      max_addr;
    logic                                   dump_start;
    logic                                   dump_done;
    logic                                   rd_en;
    logic [ADDR_SIZE-1:0]                   raddr;
    logic [NUM_CHANNELS-1:0][DATA_SIZE-1:0] rdata;
    logic [NUM_CHANNELS-1:0]                clean_end_ch;
    logic                                   clean_end_all;

    // The clean is finished only when every channel reports its end.
    assign clean_end_all = &clean_end_ch;

    iagc_controller u_controller (
        .i_clock       (i_clock),
        .i_rst_n       (i_rst_n),
        .i_cmd         (i_cmd),
        .i_cmd_valid   (i_cmd_valid),
        .o_cmd_ready   (o_cmd_ready),
        .i_frame       (i_frame),
        .i_frame_valid (i_frame_valid),
        .o_frame_ready (o_frame_ready),
        .i_clean_end   (clean_end_all),
        .i_dump_done   (dump_done),
        .o_status      (o_status),
        .o_cmd_error   (o_cmd_error),
        .o_wr_en       (wr_en),
        .o_waddr       (waddr),
        .o_wdata       (wdata),
        .o_max_addr    (max_addr),
        .o_dump_start  (dump_start)
    );

    // ============================================================
    // Channel memories
    // ============================================================

    for (genvar g = 0; g < NUM_CHANNELS; g++) begin : g_channel
        sample_memory u_memory (
            .i_clock     (i_clock),
            .i_rst_n     (i_rst_n),
            .i_status    (o_status),
            .i_wr_en     (wr_en),
            .i_waddr     (waddr),
            .i_wdata     (wdata.sample[g]),
            .i_rd_en     (rd_en),
            .i_raddr     (raddr),
            .i_max_addr  (max_addr),
            .o_clean_end (clean_end_ch[g]),
            .o_rdata     (rdata[g])
        );
    end

    dump_serializer u_serializer (
        .i_clock      (i_clock),
        .i_rst_n      (i_rst_n),
        .i_dump_start (dump_start),
        .i_max_addr   (max_addr),
        .o_rd_en      (rd_en),
        .o_raddr      (raddr),
        .i_rdata      (rdata),
        .o_dump       (o_dump),
        .o_dump_valid (o_dump_valid),
        .i_dump_ready (i_dump_ready),
        .o_dump_done  (dump_done)
    );

endmodule

// ==== tb_iagc_top.sv ====
`timescale 1ns/1ps

module tb_iagc_top;
    import iagc_pkg::*;

    logic          i_clock;
    logic          i_rst_n;
    iagc_cmd_t     i_cmd;
    logic          i_cmd_valid;
    logic          o_cmd_ready;
    sample_frame_t i_frame;
    logic          i_frame_valid;
    logic          o_frame_ready;
    dump_word_t    o_dump;
    logic          o_dump_valid;
    logic          i_dump_ready;
    iagc_status_e  o_status;
    logic          o_cmd_error;

    // Vector records, one entry per non-comment line of the file.
    logic [7:0]    rec_kind[$];
    int            rec_a[$];
    int            rec_b[$];
    int            rec_c[$];
    int            rec_d[$];

    integer        seed = 30705;
    int            cycle_count = 0;
    int            cycle_limit = 0;
    int            errors = 0;
    int            pass_count = 0;
    int            fail_count = 0;
    int            test_num = 0;
    int            test_open = 0;
    int            test_start_errors = 0;
    int            pulses_seen = 0;
    int            pulses_expected = 0;

    iagc_top uut (
        .i_clock       (i_clock),
        .i_rst_n       (i_rst_n),
        .i_cmd         (i_cmd),
        .i_cmd_valid   (i_cmd_valid),
        .o_cmd_ready   (o_cmd_ready),
        .i_frame       (i_frame),
        .i_frame_valid (i_frame_valid),
        .o_frame_ready (o_frame_ready),
        .o_dump        (o_dump),
        .o_dump_valid  (o_dump_valid),
        .i_dump_ready  (i_dump_ready),
        .o_status      (o_status),
        .o_cmd_error   (o_cmd_error)
    );

    always #50 i_clock = ~i_clock;

    // Random back-pressure on the dump stream for every dump.
    always @(posedge i_clock) begin
        i_dump_ready <= ($random(seed) & 1) != 0;
    end

    always @(posedge i_clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles in test %0d", cycle_count, test_num);
            $display("TESTS FAILED");
            $finish;
        end
    end

    always @(negedge i_clock) begin
        if (i_rst_n && o_cmd_error) begin
            pulses_seen++;
        end
    end

    // ============================================================
    // Compare tasks
    // ============================================================

    task automatic check_dump(input dump_word_t got, input dump_word_t want);
        if (got !== want) begin
            $display("[ERROR] o_dump: got %h, expected %h", got, want);
            errors++;
        end
    endtask

    task automatic check_status(input iagc_status_e got, input iagc_status_e want);
        if (got !== want) begin
            $display("[ERROR] o_status: got %h, expected %h", got, want);
            errors++;
        end
    endtask

    // ============================================================
    // Stream drivers and monitors
    // ============================================================

    task automatic send_cmd(input int op, input int param);
        iagc_cmd_t cmd;
        logic      taken;
        cmd.opcode = op[2:0];
        cmd.param  = param[SIZE_W-1:0];
        taken      = 1'b0;
        @(posedge i_clock);
        i_cmd       <= cmd;
        i_cmd_valid <= 1'b1;
        while (!taken) begin
            @(negedge i_clock);
            if (o_dump_valid && i_dump_ready) begin
                $display("unexpected dump word %h while waiting to send a command", o_dump);
                errors++;
            end
            taken = o_cmd_ready;
            @(posedge i_clock);
        end
        i_cmd_valid <= 1'b0;
    endtask

    task automatic send_frame(input int d0, input int d1, input int d2, input int d3);
        sample_frame_t frame;
        logic          taken;
        frame.sample[0] = d0[DATA_SIZE-1:0];
        frame.sample[1] = d1[DATA_SIZE-1:0];
        frame.sample[2] = d2[DATA_SIZE-1:0];
        frame.sample[3] = d3[DATA_SIZE-1:0];
        taken           = 1'b0;
        @(posedge i_clock);
        i_frame       <= frame;
        i_frame_valid <= 1'b1;
        while (!taken) begin
            @(negedge i_clock);
            taken = o_frame_ready;
            @(posedge i_clock);
        end
        i_frame_valid <= 1'b0;
    endtask

    // A word counts as received when valid and ready are both high mid-cycle.
    task automatic expect_word(input dump_word_t want);
        dump_word_t got;
        logic       taken;
        taken = 1'b0;
        got   = '0;
        while (!taken) begin
            @(negedge i_clock);
            taken = o_dump_valid && i_dump_ready;
            got   = o_dump;
            @(posedge i_clock);
        end
        check_dump(got, want);
    endtask

    task automatic expect_error();
        int pulses;
        int waited;
        pulses = 0;
        waited = 0;
        do begin
            @(negedge i_clock);
            if (o_cmd_error) begin
                pulses++;
                check_status(o_status, CMD_ERROR);
            end
            waited++;
        end while (o_status != IDLE && waited < 8);
        if (pulses != 1) begin
            $display("expected one command error pulse, saw %0d", pulses);
            errors++;
        end
    endtask

    task automatic wait_idle();
        do begin
            @(negedge i_clock);
            if (o_dump_valid && i_dump_ready) begin
                $display("unexpected dump word %h while waiting for IDLE", o_dump);
                errors++;
            end
        end while (o_status != IDLE);
    endtask

    task automatic finish_test();
        if (test_open) begin
            if (errors == test_start_errors) begin
                pass_count++;
                $display("test %0d ok", test_num);
            end else begin
                fail_count++;
                $display("test %0d failed with %0d errors", test_num, errors - test_start_errors);
            end
        end
    endtask

    task automatic load_vectors(output logic ok);
        int               fd;
        int               code;
        int               a;
        int               b;
        int               c;
        int               d;
        logic [63:0]      word;
        logic [8*200-1:0] rest;
        fd = $fopen("iagc_vectors.txt", "r");
        ok = (fd != 0);
        // The clean that follows reset is budgeted up front.
        cycle_limit = 200;
        while (ok && !$feof(fd)) begin
            code = $fscanf(fd, "%s", word);
            if (code == 1) begin
                a = 0;
                b = 0;
                c = 0;
                d = 0;
                case (word[7:0])
                    "#":      code = $fgets(rest, fd);
                    "T", "Z": code = $fscanf(fd, "%d", a);
                    "C":      code = $fscanf(fd, "%d %d", a, b);
                    "D":      code = $fscanf(fd, "%d %d %h", a, b, c);
                    "F":      code = $fscanf(fd, "%h %h %h %h", a, b, c, d);
                    default:  code = 0;
                endcase
                if (word[7:0] != "#") begin
                    rec_kind.push_back(word[7:0]);
                    rec_a.push_back(a);
                    rec_b.push_back(b);
                    rec_c.push_back(c);
                    rec_d.push_back(d);
                    cycle_limit += (word[7:0] == "Z") ? 400 * a : 400;
                    if (word[7:0] == "C" && a == OP_CLEAN) begin
                        cycle_limit += 200;
                    end
                end
            end
        end
        if (ok) begin
            $fclose(fd);
        end
    endtask

    // ============================================================
    // Main sequence
    // ============================================================

    initial begin
        dump_word_t want;
        logic       loaded;
        i_clock       = 1'b0;
        i_rst_n       = 1'b0;
        i_cmd         = '0;
        i_cmd_valid   = 1'b0;
        i_frame       = '0;
        i_frame_valid = 1'b0;
        i_dump_ready  = 1'b0;
        load_vectors(loaded);
        if (!loaded) begin
            $display("could not open iagc_vectors.txt");
            $display("TESTS FAILED");
            $finish;
        end else begin
            repeat (15) @(posedge i_clock);
            @(negedge i_clock);
            check_status(o_status, RESET);
            @(posedge i_clock);
            i_rst_n <= 1'b1;

            for (int i = 0; i < rec_kind.size(); i++) begin
                case (rec_kind[i])
                    "T": begin
                        finish_test();
                        test_num          = rec_a[i];
                        test_open         = 1;
                        test_start_errors = errors;
                    end
                    "C": send_cmd(rec_a[i], rec_b[i]);
                    "F": send_frame(rec_a[i], rec_b[i], rec_c[i], rec_d[i]);
                    "D": begin
                        want.channel = CH_W'(rec_a[i]);
                        want.addr    = ADDR_SIZE'(rec_b[i]);
                        want.data    = DATA_SIZE'(rec_c[i]);
                        expect_word(want);
                    end
                    "Z": begin
                        // Zero words follow channel order inside ascending addresses.
                        for (int n = 0; n < rec_a[i]; n++) begin
                            want.channel = CH_W'(n % NUM_CHANNELS);
                            want.addr    = ADDR_SIZE'(n / NUM_CHANNELS);
                            want.data    = '0;
                            expect_word(want);
                        end
                    end
                    "X": begin
                        pulses_expected++;
                        expect_error();
                    end
                    "W": wait_idle();
                    default: begin
                        $display("unknown record type in the vector file at entry %0d", i);
                        errors++;
                    end
                endcase
            end
            wait_idle();
            finish_test();

            if (pulses_seen != pulses_expected) begin
                $display("saw %0d command error pulses, expected %0d", pulses_seen,
                         pulses_expected);
                errors++;
            end

            $display("passed: %0d, failed: %0d", pass_count, fail_count);
            if (errors == 0 && fail_count == 0) begin
                $display("TESTS PASSED");
            end else begin
                $display("TESTS FAILED");
            end
            $finish;
        end
    end

endmodule

// ==== iagc_vectors.txt ====
# Records: T test | C opcode param | F d0 d1 d2 d3 (hex) | D channel addr data (data hex)
# Z n expects n zero words in dump order | X expects one command error | W waits for IDLE
T 1
W
C 2 0
Z 256
T 2
C 4 4
C 1 0
F 1a00 2b00 3c00 4d00
F 1a01 2b01 3c01 4d01
F 1a02 2b02 3c02 4d02
F ffff 00ff 8001 7ffe
C 2 0
D 0 0 1a00
D 1 0 2b00
D 2 0 3c00
D 3 0 4d00
D 0 1 1a01
D 1 1 2b01
D 2 1 3c01
D 3 1 4d01
D 0 2 1a02
D 1 2 2b02
D 2 2 3c02
D 3 2 4d02
D 0 3 ffff
D 1 3 00ff
D 2 3 8001
D 3 3 7ffe
T 3
C 4 2
C 1 0
F beef cafe 0bad f00d
F 5555 aaaa 0f0f f0f0
C 2 0
D 0 0 beef
D 1 0 cafe
D 2 0 0bad
D 3 0 f00d
D 0 1 5555
D 1 1 aaaa
D 2 1 0f0f
D 3 1 f0f0
T 4
C 3 0
W
C 2 0
Z 8
T 5
C 7 0
X
C 4 0
X
C 4 65
X
C 2 0
Z 8

// ==== filelist.f ====
iagc_pkg.sv
sample_memory.sv
iagc_controller.sv
dump_serializer.sv
iagc_top.sv
tb_iagc_top.sv
